// ==== test/tb_vdp_model.svh ====
// Reference model of the VDP register block, included inside the testbench
// Works from the register image reg_img kept by the testbench
`ifndef TB_VDP_MODEL_SVH
`define TB_VDP_MODEL_SVH

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// Expected control register outputs, field input held low
function automatic vdp_types_pkg::vdp_regs_t build_regs();
  vdp_types_pkg::vdp_regs_t r;
  r = '0;
  r.hsync_int_en  = reg_img[0][4];
  r.mode0         = reg_img[0][3:1];
  r.sp_zoom       = reg_img[1][0];
  r.sp_size       = reg_img[1][1];
  r.bl_clks       = reg_img[1][2];
  r.mode1         = reg_img[1][4:3];
  r.vsync_int_en  = reg_img[1][5];
  r.disp_on       = reg_img[1][6];
  r.name_addr     = reg_img[2][6:0];
  r.col_addr      = {reg_img[10][2:0], reg_img[3]};
  r.pat_addr      = reg_img[4][5:0];
  r.sp_atr_addr   = {reg_img[11][1:0], reg_img[5]};
  r.sp_gen_addr   = reg_img[6][5:0];
  r.frame_col     = reg_img[7];
  r.sp_off        = reg_img[8][1];
  r.col0_on       = reg_img[8][5];
  r.pal_mode      = reg_img[9][1];
  r.interlace     = reg_img[9][3];
  r.y_dots        = reg_img[9][7];
  r.blink_mode    = reg_img[12];
  r.blink_period  = reg_img[13];
  r.status_sel    = reg_img[15][3:0];
  r.adjust        = reg_img[18];
  r.hint_line     = reg_img[19];
  r.vstart_line   = reg_img[23];
  r.yae           = reg_img[25][4];
  r.yjk           = reg_img[25][3];
  r.msk           = reg_img[25][1];
  r.sp2           = reg_img[25][0];
  r.h_scroll      = reg_img[26][5:0];
  r.h_scroll_fine = reg_img[27][2:0];
  // Bitmap modes with two-page set show the field page
  if ((reg_img[0][3] || reg_img[0][3:1] == 3'b011) && reg_img[9][2]) begin
    r.name_addr[5] = 1'b0;
  end
  return r;
endfunction

function automatic logic [7:0] ref_status(input logic [3:0] sel,
                                          input vdp_types_pkg::status_in_t si,
                                          input logic [1:0] intn);
  case (sel)
    4'd0:    return {~intn[1], si.sp_overflow, si.sp_collision, si.sp_over_num};
    4'd1:    return {2'b00, 5'd2, ~intn[0]};
    4'd2:    return {si.cmd_tr, si.vd, si.hd, si.cmd_bd, 2'b11, 1'b0, si.cmd_ce};
    4'd3:    return si.col_x[7:0];
    4'd4:    return {7'd0, si.col_x[8]};
    4'd5:    return si.col_y[7:0];
    4'd6:    return {7'd0, si.col_y[8]};
    4'd7:    return si.cmd_clr;
    4'd8:    return si.cmd_sx[7:0];
    4'd9:    return {7'h7F, si.cmd_sx[8]};
    4'd13:   return 8'h00;
    default: return 8'hFF;
  endcase
endfunction

// M1 = R1 bit 4, M2 = R1 bit 3, M3..M5 = R0 bits 1..3
function automatic vdp_types_pkg::disp_mode_e ref_mode(input logic [7:0] r0,
                                                      input logic [7:0] r1);
  case ({r0[3], r0[2], r0[1], r1[3], r1[4]})
    5'b00000: return vdp_types_pkg::graphic1;
    5'b00001: return vdp_types_pkg::text1;
    5'b00010: return vdp_types_pkg::multi;
    5'b00100: return vdp_types_pkg::graphic2;
    5'b00101: return vdp_types_pkg::text1q;
    5'b00110: return vdp_types_pkg::multiq;
    5'b01000: return vdp_types_pkg::graphic3;
    5'b01001: return vdp_types_pkg::text2;
    5'b01100: return vdp_types_pkg::graphic4;
    5'b10000: return vdp_types_pkg::graphic5;
    5'b10100: return vdp_types_pkg::graphic6;
    5'b11100: return vdp_types_pkg::graphic7;
    default:  return vdp_types_pkg::mode_none;
  endcase
endfunction

function automatic logic [16:0] ref_vram_addr(input logic [7:0] r14, input logic [7:0] b1,
                                              input logic [7:0] b2);
  return {r14[2:0], b2[5:0], b1};
endfunction

`endif

// ==== test/tb_vdp_register.sv ====
// Testbench for the VDP register block top level
// Drives CPU port cycles and checks against the included reference model
`timescale 1ns/10ps
`default_nettype none

module tb_vdp_register;

  localparam int n_tests      = 6;
  localparam int cycle_budget = 600;

  logic reset;
  logic clk21m;
  logic req;
  logic ack;
  logic wrt;
  vdp_types_pkg::port_sel_e mode;
  logic [7:0] dbo;
  logic [7:0] dbi;
  logic hsync;
  logic field;
  logic [1:0] int_n;
  vdp_types_pkg::status_in_t status_in;
  logic clr_vsync_int;
  logic clr_hsync_int;
  logic vram_addr_set_ack;
  logic vram_wr_ack;
  logic vram_rd_ack;
  logic [7:0] vram_rd_data;
  vdp_types_pkg::vram_req_t vram;
  logic cmd_ack;
  vdp_types_pkg::cmd_wr_t cmd;
  vdp_types_pkg::toggle_ack_t toggle_ack;
  logic sp_s0_reset_req;
  logic sp_s5_reset_req;
  logic cmd_tr_clr_req;
  vdp_types_pkg::vdp_regs_t regs;
  vdp_types_pkg::disp_mode_e disp_mode;

  logic [31:0] seed;
  logic [7:0]  reg_img [0:27];
  int err_cnt;
  int check_cnt;
  int test_base;
  int test_num;
  int vs_cnt;
  int hs_cnt;

  `include "tb_vdp_model.svh"

  vdp_register u_dut (
    .reset(reset), .clk21m(clk21m), .req(req), .ack(ack), .wrt(wrt), .mode(mode),
    .dbo(dbo), .dbi(dbi), .hsync(hsync), .field(field), .int_n(int_n),
    .status_in(status_in), .clr_vsync_int(clr_vsync_int), .clr_hsync_int(clr_hsync_int),
    .vram_addr_set_ack(vram_addr_set_ack), .vram_wr_ack(vram_wr_ack),
    .vram_rd_ack(vram_rd_ack), .vram_rd_data(vram_rd_data), .vram(vram),
    .cmd_ack(cmd_ack), .cmd(cmd), .toggle_ack(toggle_ack),
    .sp_s0_reset_req(sp_s0_reset_req), .sp_s5_reset_req(sp_s5_reset_req),
    .cmd_tr_clr_req(cmd_tr_clr_req), .regs(regs), .disp_mode(disp_mode)
  );

  // reset is the clock of this block
  initial reset = 1'b0;
  always #4 reset = ~reset;

  // Clear pulses sampled before the edge updates them
  always @(posedge reset) begin
    if (clr_vsync_int) vs_cnt = vs_cnt + 1;
    if (clr_hsync_int) hs_cnt = hs_cnt + 1;
  end

  initial begin
    #(n_tests * cycle_budget * 8);
    $display("Watchdog timeout: the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic logic [31:0] rand32();
    seed = lcg_next(seed);
    return seed;
  endfunction

  task automatic tick(input int n);
    repeat (n) @(negedge reset);
  endtask

  task automatic bus_write(input vdp_types_pkg::port_sel_e p, input logic [7:0] d);
    @(negedge reset);
    check("ack", 1'b0, ack);
    req  = 1'b1;
    wrt  = 1'b1;
    mode = p;
    dbo  = d;
    @(negedge reset);
    check("ack", 1'b1, ack);
    req = 1'b0;
    wrt = 1'b0;
  endtask

  task automatic bus_read(input vdp_types_pkg::port_sel_e p);
    @(negedge reset);
    check("ack", 1'b0, ack);
    req  = 1'b1;
    wrt  = 1'b0;
    mode = p;
    @(negedge reset);
    check("ack", 1'b1, ack);
    req = 1'b0;
  endtask

  // Register write through the two-byte control sequence
  task automatic write_reg(input int n, input logic [7:0] d);
    bus_write(vdp_types_pkg::port_ctrl, d);
    bus_write(vdp_types_pkg::port_ctrl, 8'h80 | n[5:0]);
    if (n < 28) reg_img[n] = d;
  endtask

  task automatic hsync_pulse();
    @(negedge reset);
    hsync = 1'b1;
    @(negedge reset);
    hsync = 1'b0;
  endtask

  task automatic check(input string name, input logic [255:0] exp, input logic [255:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %s: expected %0h got %0h", name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, err_cnt - test_base);
    test_base = err_cnt;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [63:0] w;
    logic [16:0] a;
    logic [7:0]  d;
    logic [7:0]  m0;
    logic [7:0]  m1;
    seed = 32'h7439_db11;
    clk21m = 1'b1;
    req = 1'b0;
    wrt = 1'b0;
    mode = vdp_types_pkg::port_vram;
    dbo = '0;
    hsync = 1'b0;
    field = 1'b0;
    int_n = 2'b11;
    status_in = '0;
    vram_addr_set_ack = 1'b0;
    vram_wr_ack = 1'b0;
    vram_rd_ack = 1'b0;
    vram_rd_data = '0;
    cmd_ack = 1'b0;
    toggle_ack = '0;
    err_cnt = 0;
    check_cnt = 0;
    test_base = 0;
    test_num = 0;
    vs_cnt = 0;
    hs_cnt = 0;
    for (int i = 0; i < 28; i++) reg_img[i] = '0;
    tick(16);
    clk21m = 1'b0;
    tick(2);

    // ------------------------------
    // Direct writes through port 1
    // ------------------------------
    for (int n = 0; n < 28; n++) begin
      if (n != 14 && n != 16 && n != 17) begin
        r = rand32();
        write_reg(n, r[7:0]);
      end
    end
    tick(2);
    hsync_pulse();
    check("regs", build_regs(), regs);
    end_test("direct writes");

    // Indirect writes, auto-increment then fixed pointer
    write_reg(17, 8'd18);
    for (int n = 18; n < 21; n++) begin
      r = rand32();
      bus_write(vdp_types_pkg::port_indirect, r[7:0]);
      reg_img[n] = r[7:0];
    end
    write_reg(17, 8'h80 | 8'd23);
    repeat (2) begin
      r = rand32();
      bus_write(vdp_types_pkg::port_indirect, r[7:0]);
      reg_img[23] = r[7:0];
    end
    write_reg(17, 8'h80 | 8'd17);
    // Pointer fixed on R17 drops both bytes
    bus_write(vdp_types_pkg::port_indirect, 8'h13);
    bus_write(vdp_types_pkg::port_indirect, ~reg_img[19]);
    tick(2);
    check("regs", build_regs(), regs);
    end_test("indirect writes");

    // ------------------------------
    // Status read multiplexer
    // ------------------------------
    for (int s = 0; s < 16; s++) begin
      write_reg(15, s[7:0]);
      tick(2);
      r  = rand32();
      r2 = rand32();
      w  = {r, r2};
      status_in = w[$bits(status_in)-1:0];
      int_n = r2[31:30];
      bus_read(vdp_types_pkg::port_ctrl);
      check("dbi", ref_status(s[3:0], status_in, int_n), dbi);
    end
    bus_read(vdp_types_pkg::port_palette);
    check("dbi", 8'hFF, dbi);
    end_test("status mux");

    // Interrupt clear pulses
    write_reg(15, 8'd0);
    tick(2);
    vs_cnt = 0;
    hs_cnt = 0;
    toggle_ack.sp_s0_ack = sp_s0_reset_req;
    bus_read(vdp_types_pkg::port_ctrl);
    tick(3);
    check("clr_vsync_int count", 1, vs_cnt);
    check("clr_hsync_int count", 0, hs_cnt);
    check("sp_s0_reset_req", !toggle_ack.sp_s0_ack, sp_s0_reset_req);
    write_reg(15, 8'd1);
    tick(2);
    vs_cnt = 0;
    hs_cnt = 0;
    bus_read(vdp_types_pkg::port_ctrl);
    tick(3);
    check("clr_vsync_int count", 0, vs_cnt);
    check("clr_hsync_int count", 1, hs_cnt);
    // Sprite S#5 reset and transfer-ready clear toggles
    write_reg(15, 8'd5);
    tick(2);
    toggle_ack.sp_s5_ack = sp_s5_reset_req;
    bus_read(vdp_types_pkg::port_ctrl);
    check("sp_s5_reset_req", !toggle_ack.sp_s5_ack, sp_s5_reset_req);
    write_reg(15, 8'd7);
    tick(2);
    toggle_ack.cmd_tr_clr_ack = cmd_tr_clr_req;
    bus_read(vdp_types_pkg::port_ctrl);
    check("cmd_tr_clr_req", !toggle_ack.cmd_tr_clr_ack, cmd_tr_clr_req);
    hs_cnt = 0;
    write_reg(19, 8'h40);
    tick(3);
    check("clr_hsync_int count", 1, hs_cnt);
    hs_cnt = 0;
    write_reg(0, 8'h10);
    tick(3);
    check("clr_hsync_int count", 1, hs_cnt);
    hs_cnt = 0;
    write_reg(0, 8'h00);
    tick(3);
    check("clr_hsync_int count", 0, hs_cnt);
    end_test("interrupt clears");

    // ------------------------------
    // VRAM address, write and read
    // ------------------------------
    r = rand32();
    a = r[16:0];
    write_reg(14, {5'd0, a[16:14]});
    check("vram.addr_set_req", !vram_addr_set_ack, vram.addr_set_req);
    vram_addr_set_ack = vram.addr_set_req;
    bus_write(vdp_types_pkg::port_ctrl, a[7:0]);
    bus_write(vdp_types_pkg::port_ctrl, {2'b01, a[13:8]});
    check("vram.addr", ref_vram_addr({5'd0, a[16:14]}, a[7:0], {2'b01, a[13:8]}), vram.addr);
    check("vram.addr_set_req", !vram_addr_set_ack, vram.addr_set_req);
    d = r[31:24];
    bus_write(vdp_types_pkg::port_vram, d);
    check("vram.wr_data", d, vram.wr_data);
    check("vram.wr_req", !vram_wr_ack, vram.wr_req);
    vram_addr_set_ack = vram.addr_set_req;
    a[13:0] = r[30:17];
    bus_write(vdp_types_pkg::port_ctrl, a[7:0]);
    bus_write(vdp_types_pkg::port_ctrl, {2'b00, a[13:8]});
    check("vram.addr", ref_vram_addr({5'd0, a[16:14]}, a[7:0], {2'b00, a[13:8]}), vram.addr);
    check("vram.addr_set_req", !vram_addr_set_ack, vram.addr_set_req);
    check("vram.rd_req", !vram_rd_ack, vram.rd_req);
    r = rand32();
    vram_rd_data = r[7:0];
    vram_rd_ack = vram.rd_req;
    bus_read(vdp_types_pkg::port_vram);
    check("dbi", r[7:0], dbi);
    check("vram.rd_req", !vram_rd_ack, vram.rd_req);
    end_test("vram access");

    // Display modes, then command engine forwarding
    for (int i = 0; i < 8; i++) begin
      r  = rand32();
      m0 = {4'd0, r[2:0], 1'b0};
      m1 = {1'b0, 1'b1, 1'b0, r[4:3], 3'b000};
      write_reg(0, m0);
      write_reg(1, m1);
      tick(1);
      hsync_pulse();
      check("disp_mode", ref_mode(m0, m1), disp_mode);
    end
    for (int n = 32; n < 48; n++) begin
      r = rand32();
      write_reg(n, r[7:0]);
      tick(1);
      check("cmd.num", n - 32, cmd.num);
      check("cmd.data", r[7:0], cmd.data);
      check("cmd.req", !cmd_ack, cmd.req);
      cmd_ack = cmd.req;
    end
    end_test("modes and command");

    $display("%0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_cfg_pkg.sv ====
// Widths, register numbers and status numbers of the VDP register block
// Referenced by scoped name from the types package and the RTL stages
`default_nettype none

package vdp_cfg_pkg;

  // Bus and field widths
  localparam int data_w       = 8;
  localparam int reg_ptr_w    = 6;
  localparam int vram_addr_w  = 17;
  localparam int cmd_reg_w    = 4;
  localparam int status_num_w = 4;

  // Reported in S#1 bits 5..1
  localparam logic [4:0] vdp_id = 5'd2;

  // ------------------------------
  // Control register numbers
  // ------------------------------
  localparam logic [reg_ptr_w-1:0] r_mode0      = 6'd0;
  localparam logic [reg_ptr_w-1:0] r_mode1      = 6'd1;
  localparam logic [reg_ptr_w-1:0] r_name       = 6'd2;
  localparam logic [reg_ptr_w-1:0] r_vram_hi    = 6'd14;
  localparam logic [reg_ptr_w-1:0] r_status_sel = 6'd15;
  localparam logic [reg_ptr_w-1:0] r_indirect   = 6'd17;
  localparam logic [reg_ptr_w-1:0] r_hint_line  = 6'd19;

  // ------------------------------
  // Status register numbers
  // ------------------------------
  localparam logic [status_num_w-1:0] s_int   = 4'd0;
  localparam logic [status_num_w-1:0] s_hint  = 4'd1;
  localparam logic [status_num_w-1:0] s_color = 4'd7;

endpackage

`default_nettype wire

// ==== verilog/vdp_port_decode.sv ====
// Decode stage: CPU port sequencer, R14 and R17 pointers, VRAM toggles
// Emits one-cycle register write pulses to the execute and result stages
`default_nettype none
`timescale 1ns/10ps

module vdp_port_decode (
  input  logic                              reset,
  input  logic                              clk21m,
  input  logic                              req,
  input  logic                              wrt,
  input  vdp_types_pkg::port_sel_e          mode,
  input  logic [vdp_cfg_pkg::data_w-1:0]    dbo,
  input  logic [2:0]                        vram_ack,
  output vdp_types_pkg::reg_wr_t            reg_wr,
  output vdp_types_pkg::vram_req_t          vram
);

  // vram_ack bits follow vram_req_t order: addr set, write, read
  logic                                first_byte;
  logic [vdp_cfg_pkg::data_w-1:0]      p1_data;
  logic [vdp_cfg_pkg::reg_ptr_w-1:0]   r17_ptr;
  logic                                r17_inc;
  vdp_types_pkg::ctrl_op_e             op;
  logic                                cpu_wr;
  logic                                cpu_rd;
  logic                                wr_hit;
  logic [vdp_cfg_pkg::reg_ptr_w-1:0]   wr_ptr;
  logic [vdp_cfg_pkg::data_w-1:0]      wr_data;

  assign cpu_wr = req & wrt;
  assign cpu_rd = req & ~wrt;
  assign op     = vdp_types_pkg::ctrl_op_e'(dbo[7:6]);

  // Register write from a second control byte or an indirect port write
  always_comb begin
    wr_hit  = 1'b0;
    wr_ptr  = r17_ptr;
    wr_data = dbo;
    if (cpu_wr && mode == vdp_types_pkg::port_ctrl && !first_byte &&
        (op == vdp_types_pkg::op_reg_sel || op == vdp_types_pkg::op_reg_sel_alt)) begin
      wr_hit  = 1'b1;
      wr_ptr  = dbo[5:0];
      wr_data = p1_data;
    end else if (cpu_wr && mode == vdp_types_pkg::port_indirect &&
                 r17_ptr != vdp_cfg_pkg::r_indirect) begin
      // R17 cannot point at itself
      wr_hit = 1'b1;
    end
  end

  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      first_byte <= 1'b1;
      p1_data    <= '0;
      r17_ptr    <= '0;
      r17_inc    <= 1'b0;
      reg_wr     <= '0;
      vram       <= '0;
    end else begin
      reg_wr.valid <= wr_hit;
      if (wr_hit) begin
        reg_wr.ptr  <= wr_ptr;
        reg_wr.data <= wr_data;
      end

      if (cpu_rd) begin
        if (mode == vdp_types_pkg::port_vram) begin
          vram.rd_req <= ~vram_ack[0];
        end else if (mode == vdp_types_pkg::port_ctrl) begin
          // Status read restarts the two-byte sequence
          first_byte <= 1'b1;
        end
      end else if (cpu_wr) begin
        case (mode)
          vdp_types_pkg::port_vram: begin
            vram.wr_data <= dbo;
            vram.wr_req  <= ~vram_ack[1];
          end
          vdp_types_pkg::port_ctrl: begin
            first_byte <= ~first_byte;
            if (first_byte) begin
              p1_data <= dbo;
            end else if (op == vdp_types_pkg::op_addr_read ||
                         op == vdp_types_pkg::op_addr_write) begin
              vram.addr[13:0]   <= {dbo[5:0], p1_data};
              vram.addr_set_req <= ~vram_ack[2];
              if (op == vdp_types_pkg::op_addr_read) begin
                // Prefetch for the next port 0 read
                vram.rd_req <= ~vram_ack[0];
              end
            end
          end
          vdp_types_pkg::port_indirect: begin
            if (r17_inc) begin
              r17_ptr <= r17_ptr + 6'd1;
            end
          end
          default: begin
          end
        endcase
      end

      // ------------------------------
      // Registers held in this stage
      // ------------------------------
      if (wr_hit && wr_ptr == vdp_cfg_pkg::r_vram_hi) begin
        vram.addr[16:14]  <= wr_data[2:0];
        vram.addr_set_req <= ~vram_ack[2];
      end
      if (wr_hit && wr_ptr == vdp_cfg_pkg::r_indirect) begin
        r17_ptr <= wr_data[5:0];
        r17_inc <= ~wr_data[7];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_reg_execute.sv ====
// Execute stage: control register file R0 to R27 and command forwarding
// Mode, display-on, sp2 and coarse scroll take effect during hsync
`default_nettype none
`timescale 1ns/10ps

module vdp_reg_execute (
  input  logic                        reset,
  input  logic                        clk21m,
  input  logic                        hsync,
  input  logic                        field,
  input  vdp_types_pkg::reg_wr_t      reg_wr,
  input  logic                        cmd_ack,
  output vdp_types_pkg::vdp_regs_t    regs,
  output vdp_types_pkg::cmd_wr_t      cmd
);

  vdp_types_pkg::vdp_regs_t  regs_q;
  logic [2:0]                mode0_p;
  logic [1:0]                mode1_p;
  logic                      disp_on_p;
  logic                      sp2_p;
  logic [5:0]                h_scroll_p;
  logic                      two_page;
  logic                      bitmap;
  logic [7:0]                d;

  assign d      = reg_wr.data;
  assign bitmap = regs_q.mode0[2] | (regs_q.mode0 == 3'b011);

  // Two-page mode swaps the name table page on each field
  always_comb begin
    regs = regs_q;
    if (bitmap && two_page) begin
      regs.name_addr[5] = field;
    end
  end

  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      regs_q     <= '0;
      mode0_p    <= '0;
      mode1_p    <= '0;
      disp_on_p  <= 1'b0;
      sp2_p      <= 1'b0;
      h_scroll_p <= '0;
      two_page   <= 1'b0;
    end else begin
      if (hsync) begin
        regs_q.mode0    <= mode0_p;
        regs_q.mode1    <= mode1_p;
        regs_q.disp_on  <= disp_on_p;
        regs_q.sp2      <= sp2_p;
        regs_q.h_scroll <= h_scroll_p;
      end

      if (reg_wr.valid && !reg_wr.ptr[5]) begin
        case (reg_wr.ptr)
          vdp_cfg_pkg::r_mode0: begin
            mode0_p             <= d[3:1];
            regs_q.hsync_int_en <= d[4];
          end
          vdp_cfg_pkg::r_mode1: begin
            regs_q.sp_zoom      <= d[0];
            regs_q.sp_size      <= d[1];
            regs_q.bl_clks      <= d[2];
            mode1_p             <= d[4:3];
            regs_q.vsync_int_en <= d[5];
            disp_on_p           <= d[6];
          end
          vdp_cfg_pkg::r_name: regs_q.name_addr <= d[6:0];
          6'd3:  regs_q.col_addr[7:0] <= d;
          6'd4:  regs_q.pat_addr <= d[5:0];
          6'd5:  regs_q.sp_atr_addr[7:0] <= d;
          6'd6:  regs_q.sp_gen_addr <= d[5:0];
          6'd7:  regs_q.frame_col <= d;
          6'd8: begin
            regs_q.sp_off  <= d[1];
            regs_q.col0_on <= d[5];
          end
          6'd9: begin
            regs_q.pal_mode  <= d[1];
            two_page         <= d[2];
            regs_q.interlace <= d[3];
            regs_q.y_dots    <= d[7];
          end
          6'd10: regs_q.col_addr[10:8] <= d[2:0];
          6'd11: regs_q.sp_atr_addr[9:8] <= d[1:0];
          6'd12: regs_q.blink_mode <= d;
          6'd13: regs_q.blink_period <= d;
          vdp_cfg_pkg::r_status_sel: regs_q.status_sel <= d[3:0];
          6'd18: regs_q.adjust <= d;
          vdp_cfg_pkg::r_hint_line: regs_q.hint_line <= d;
          6'd23: regs_q.vstart_line <= d;
          6'd25: begin
            regs_q.yae <= d[4];
            regs_q.yjk <= d[3];
            regs_q.msk <= d[1];
            sp2_p      <= d[0];
          end
          6'd26: h_scroll_p <= d[5:0];
          6'd27: regs_q.h_scroll_fine <= d[2:0];
          // R14, R16 and R17 have no fields here
          default: begin
          end
        endcase
      end
    end
  end

  // ------------------------------
  // R32 to R47 go to the command engine
  // ------------------------------
  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      cmd <= '0;
    end else if (reg_wr.valid && reg_wr.ptr[5:4] == 2'b10) begin
      cmd.num  <= reg_wr.ptr[3:0];
      cmd.data <= d;
      cmd.req  <= ~cmd_ack;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_register.sv ====
// Top level of the VDP CPU register block
// Chains decode, execute and result stages and registers the bus acknowledge
`default_nettype none
`timescale 1ns/10ps

module vdp_register (
  input  logic                              reset,
  input  logic                              clk21m,
  input  logic                              req,
  output logic                              ack,
  input  logic                              wrt,
  input  vdp_types_pkg::port_sel_e          mode,
  input  logic [vdp_cfg_pkg::data_w-1:0]    dbo,
  output logic [vdp_cfg_pkg::data_w-1:0]    dbi,
  input  logic                              hsync,
  input  logic                              field,
  input  logic [1:0]                        int_n,
  input  vdp_types_pkg::status_in_t         status_in,
  output logic                              clr_vsync_int,
  output logic                              clr_hsync_int,
  input  logic                              vram_addr_set_ack,
  input  logic                              vram_wr_ack,
  input  logic                              vram_rd_ack,
  input  logic [vdp_cfg_pkg::data_w-1:0]    vram_rd_data,
  output vdp_types_pkg::vram_req_t          vram,
  input  logic                              cmd_ack,
  output vdp_types_pkg::cmd_wr_t            cmd,
  input  vdp_types_pkg::toggle_ack_t        toggle_ack,
  output logic                              sp_s0_reset_req,
  output logic                              sp_s5_reset_req,
  output logic                              cmd_tr_clr_req,
  output vdp_types_pkg::vdp_regs_t          regs,
  output vdp_types_pkg::disp_mode_e         disp_mode
);

  vdp_types_pkg::reg_wr_t  reg_wr;
  logic [2:0]              toggle_req;

  assign {sp_s0_reset_req, sp_s5_reset_req, cmd_tr_clr_req} = toggle_req;

  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  vdp_port_decode u_decode (
    .reset    (reset),
    .clk21m   (clk21m),
    .req      (req),
    .wrt      (wrt),
    .mode     (mode),
    .dbo      (dbo),
    .vram_ack ({vram_addr_set_ack, vram_wr_ack, vram_rd_ack}),
    .reg_wr   (reg_wr),
    .vram     (vram)
  );

  vdp_reg_execute u_execute (
    .reset   (reset),
    .clk21m  (clk21m),
    .hsync   (hsync),
    .field   (field),
    .reg_wr  (reg_wr),
    .cmd_ack (cmd_ack),
    .regs    (regs),
    .cmd     (cmd)
  );

  vdp_status_result u_result (
    .reset         (reset),
    .clk21m        (clk21m),
    .req           (req),
    .wrt           (wrt),
    .mode          (mode),
    .status_in     (status_in),
    .int_n         (int_n),
    .regs          (regs),
    .reg_wr        (reg_wr),
    .vram_rd_data  (vram_rd_data),
    .toggle_ack    (toggle_ack),
    .dbi           (dbi),
    .clr_vsync_int (clr_vsync_int),
    .clr_hsync_int (clr_hsync_int),
    .toggle_req    (toggle_req),
    .disp_mode     (disp_mode)
  );

endmodule

`default_nettype wire

// ==== verilog/vdp_status_result.sv ====
// Result stage: status read mux, interrupt clear pulses, read side effects
// Also decodes the display mode from the shadowed mode bits
`default_nettype none
`timescale 1ns/10ps

module vdp_status_result (
  input  logic                              reset,
  input  logic                              clk21m,
  input  logic                              req,
  input  logic                              wrt,
  input  vdp_types_pkg::port_sel_e          mode,
  input  vdp_types_pkg::status_in_t         status_in,
  input  logic [1:0]                        int_n,
  input  vdp_types_pkg::vdp_regs_t          regs,
  input  vdp_types_pkg::reg_wr_t            reg_wr,
  input  logic [vdp_cfg_pkg::data_w-1:0]    vram_rd_data,
  input  vdp_types_pkg::toggle_ack_t        toggle_ack,
  output logic [vdp_cfg_pkg::data_w-1:0]    dbi,
  output logic                              clr_vsync_int,
  output logic                              clr_hsync_int,
  output logic [2:0]                        toggle_req,
  output vdp_types_pkg::disp_mode_e         disp_mode
);

  // int_n is {vsync, hsync}; toggle_req follows toggle_ack_t order
  logic                              rd_status;
  logic [vdp_cfg_pkg::data_w-1:0]    status_byte;

  assign rd_status = req & ~wrt & (mode == vdp_types_pkg::port_ctrl);

  always_comb begin
    case (regs.status_sel)
      vdp_cfg_pkg::s_int: status_byte = {~int_n[1], status_in.sp_overflow,
                                         status_in.sp_collision, status_in.sp_over_num};
      vdp_cfg_pkg::s_hint: status_byte = {2'b00, vdp_cfg_pkg::vdp_id, ~int_n[0]};
      // Field bit reads as zero
      4'd2: status_byte = {status_in.cmd_tr, status_in.vd, status_in.hd, status_in.cmd_bd,
                           2'b11, 1'b0, status_in.cmd_ce};
      4'd3: status_byte = status_in.col_x[7:0];
      4'd4: status_byte = {7'd0, status_in.col_x[8]};
      4'd5: status_byte = status_in.col_y[7:0];
      4'd6: status_byte = {7'd0, status_in.col_y[8]};
      vdp_cfg_pkg::s_color: status_byte = status_in.cmd_clr;
      4'd8: status_byte = status_in.cmd_sx[7:0];
      4'd9: status_byte = {7'b1111111, status_in.cmd_sx[8]};
      4'd13: status_byte = 8'h00;
      default: status_byte = 8'hFF;
    endcase
  end

  always_ff @(posedge reset, posedge clk21m) begin
    if (clk21m) begin
      dbi           <= '0;
      clr_vsync_int <= 1'b0;
      clr_hsync_int <= 1'b0;
      toggle_req    <= '0;
    end else begin
      clr_vsync_int <= rd_status && regs.status_sel == vdp_cfg_pkg::s_int;
      // Also cleared by writing R19 or setting the R0 enable bit
      clr_hsync_int <= (rd_status && regs.status_sel == vdp_cfg_pkg::s_hint) ||
                       (reg_wr.valid && (reg_wr.ptr == vdp_cfg_pkg::r_hint_line ||
                        (reg_wr.ptr == vdp_cfg_pkg::r_mode0 && reg_wr.data[4])));
      if (req && !wrt) begin
        case (mode)
          vdp_types_pkg::port_vram: dbi <= vram_rd_data;
          vdp_types_pkg::port_ctrl: dbi <= status_byte;
          default:                  dbi <= 8'hFF;
        endcase
      end
      if (rd_status) begin
        case (regs.status_sel)
          vdp_cfg_pkg::s_int:   toggle_req[2] <= ~toggle_ack.sp_s0_ack;
          4'd5:                 toggle_req[1] <= ~toggle_ack.sp_s5_ack;
          vdp_cfg_pkg::s_color: toggle_req[0] <= ~toggle_ack.cmd_tr_clr_ack;
          default: begin
          end
        endcase
      end
    end
  end

  // ------------------------------
  // Display mode from M5..M1
  // ------------------------------
  always_comb begin
    case ({regs.mode0, regs.mode1[0], regs.mode1[1]})
      5'b00000: disp_mode = vdp_types_pkg::graphic1;
      5'b00001: disp_mode = vdp_types_pkg::text1;
      5'b00010: disp_mode = vdp_types_pkg::multi;
      5'b00100: disp_mode = vdp_types_pkg::graphic2;
      5'b00101: disp_mode = vdp_types_pkg::text1q;
      5'b00110: disp_mode = vdp_types_pkg::multiq;
      5'b01000: disp_mode = vdp_types_pkg::graphic3;
      5'b01001: disp_mode = vdp_types_pkg::text2;
      5'b01100: disp_mode = vdp_types_pkg::graphic4;
      5'b10000: disp_mode = vdp_types_pkg::graphic5;
      5'b10100: disp_mode = vdp_types_pkg::graphic6;
      5'b11100: disp_mode = vdp_types_pkg::graphic7;
      default:  disp_mode = vdp_types_pkg::mode_none;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/vdp_types_pkg.sv ====
// Enums and packed structs passed between the VDP register stages
// Referenced by scoped name, never imported
`default_nettype none

package vdp_types_pkg;

  typedef enum logic [1:0] {
    port_vram,
    port_ctrl,
    port_palette,
    port_indirect
  } port_sel_e;

  // Top two bits of the second control byte
  typedef enum logic [1:0] {
    op_addr_read,
    op_addr_write,
    op_reg_sel,
    op_reg_sel_alt
  } ctrl_op_e;

  typedef enum logic [3:0] {
    graphic1, graphic2, graphic3, graphic4, graphic5, graphic6, graphic7,
    text1, text1q, text2, multi, multiq, mode_none
  } disp_mode_e;

  typedef struct packed {
    logic                                valid;
    logic [vdp_cfg_pkg::reg_ptr_w-1:0]   ptr;
    logic [vdp_cfg_pkg::data_w-1:0]      data;
  } reg_wr_t;

  // Sprite and command engine status inputs
  typedef struct packed {
    logic        sp_collision;
    logic        sp_overflow;
    logic [4:0]  sp_over_num;
    logic [8:0]  col_x;
    logic [8:0]  col_y;
    logic        cmd_tr;
    logic        vd;
    logic        hd;
    logic        cmd_bd;
    logic        cmd_ce;
    logic [7:0]  cmd_clr;
    logic [10:0] cmd_sx;
  } status_in_t;

  typedef struct packed {
    logic sp_s0_ack;
    logic sp_s5_ack;
    logic cmd_tr_clr_ack;
  } toggle_ack_t;

  typedef struct packed {
    logic        hsync_int_en;
    logic        vsync_int_en;
    logic        sp_size;
    logic        sp_zoom;
    logic        bl_clks;
    logic        disp_on;
    logic [6:0]  name_addr;
    logic [10:0] col_addr;
    logic [5:0]  pat_addr;
    logic [9:0]  sp_atr_addr;
    logic [5:0]  sp_gen_addr;
    logic [7:0]  frame_col;
    logic        sp_off;
    logic        col0_on;
    logic        pal_mode;
    logic        interlace;
    logic        y_dots;
    logic [7:0]  blink_mode;
    logic [7:0]  blink_period;
    logic [7:0]  adjust;
    logic [7:0]  hint_line;
    logic [7:0]  vstart_line;
    logic        yae;
    logic        yjk;
    logic        msk;
    logic        sp2;
    logic [5:0]  h_scroll;
    logic [2:0]  h_scroll_fine;
    logic [2:0]  mode0;
    logic [1:0]  mode1;
    logic [vdp_cfg_pkg::status_num_w-1:0] status_sel;
  } vdp_regs_t;

  typedef struct packed {
    logic [vdp_cfg_pkg::vram_addr_w-1:0] addr;
    logic [vdp_cfg_pkg::data_w-1:0]      wr_data;
    logic                                addr_set_req;
    logic                                wr_req;
    logic                                rd_req;
  } vram_req_t;

  typedef struct packed {
    logic [vdp_cfg_pkg::cmd_reg_w-1:0] num;
    logic [vdp_cfg_pkg::data_w-1:0]    data;
    logic                              req;
  } cmd_wr_t;

endpackage

`default_nettype wire

// ==== vlog.f ====
+incdir+test
verilog/vdp_cfg_pkg.sv
verilog/vdp_types_pkg.sv
verilog/vdp_port_decode.sv
verilog/vdp_reg_execute.sv
verilog/vdp_status_result.sv
verilog/vdp_register.sv
test/tb_vdp_register.sv
